// ==== include/ifu_consts.svh ====
`ifndef IFU_CONSTS_SVH
`define IFU_CONSTS_SVH

// first pc fetched after reset.
`define IFU_PC_INIT 32'h8000_0000

// direct-mapped L1I geometry with 4 sets of two 32-bit words.
`define IFU_L1I_SETS 4
`define IFU_L1I_IDX_W 2
`define IFU_L1I_TAG_W 27

// major opcodes seen by the predecoder.
`define IFU_OP_JAL 7'b1101111
`define IFU_OP_JALR 7'b1100111
`define IFU_OP_BRANCH 7'b1100011
`define IFU_OP_SYSTEM 7'b1110011
`define IFU_OP_LOAD 7'b0000011

// fence.i with rd, rs1 and imm all zero.
`define IFU_INST_FENCE_I 32'h0000_100f

`endif

// ==== verilog/ifu_pkg.sv ====
package ifu_pkg;

  // read request toward memory that is held until the matching response.
  typedef struct packed {
    logic [31:0] araddr;
    logic        arvalid;
  } bus_req_t;

  // read response whose rvalid is a single-cycle strobe.
  typedef struct packed {
    logic [31:0] rdata;
    logic        rvalid;
  } bus_rsp_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_out_t;

  // backend redirect that is sampled together with prev_valid_i.
  typedef struct packed {
    logic [31:0] npc;
    logic        pc_valid;
    logic        pc_skip;
  } redirect_t;

  typedef enum logic [1:0] {
    CLASS_PLAIN   = 2'd0,
    CLASS_XFER    = 2'd1,
    CLASS_LOAD    = 2'd2,
    CLASS_FENCE_I = 2'd3
  } inst_class_t;

endpackage

// ==== verilog/l1i_cache.sv ====
`include "ifu_consts.svh"

module l1i_cache (
  input  logic               clk,
  input  logic               rst,
  input  logic [31:0]        pc_i,
  input  logic               flush_i,
  input  ifu_pkg::bus_rsp_t  bus_rsp_i,
  output ifu_pkg::bus_req_t  bus_req_o,
  output logic               hit_o,
  output logic [31:0]        inst_o
);

  typedef enum logic [1:0] {
    REFILL_IDLE = 2'd0,
    REFILL_EVEN = 2'd1,
    REFILL_GAP  = 2'd2,
    REFILL_ODD  = 2'd3
  } refill_state_t;

  refill_state_t state_q;

  logic [31:0]                 data_q [`IFU_L1I_SETS][2];
  logic [`IFU_L1I_TAG_W-1:0]   tag_q [`IFU_L1I_SETS];
  logic [`IFU_L1I_SETS-1:0]    valid_q;

  // the line address of the refill in flight holds bits 31 to 3 of the missing pc.
  logic [31:3]                 refill_line_q;

  logic [`IFU_L1I_IDX_W-1:0]   pc_idx;
  logic [`IFU_L1I_TAG_W-1:0]   pc_tag;
  logic                        pc_off;
  logic [`IFU_L1I_IDX_W-1:0]   refill_idx;
  logic [`IFU_L1I_TAG_W-1:0]   refill_tag;

  assign pc_off = pc_i[2];
  assign pc_idx = pc_i[3 +: `IFU_L1I_IDX_W];
  assign pc_tag = pc_i[31 -: `IFU_L1I_TAG_W];

  assign refill_idx = refill_line_q[3 +: `IFU_L1I_IDX_W];
  assign refill_tag = refill_line_q[31 -: `IFU_L1I_TAG_W];

  assign hit_o  = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign inst_o = data_q[pc_idx][pc_off];

  // arvalid drops in the gap state, which separates the two reads.
  assign bus_req_o.arvalid = (state_q == REFILL_EVEN) || (state_q == REFILL_ODD);
  assign bus_req_o.araddr  = {refill_line_q, state_q == REFILL_ODD, 2'b00};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= REFILL_IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        REFILL_IDLE: begin
          if (!hit_o) begin
            state_q <= REFILL_EVEN;
            // the old line in this set is about to be overwritten.
            valid_q[pc_idx] <= 1'b0;
          end
        end
        REFILL_EVEN: begin
          if (bus_rsp_i.rvalid) begin
            state_q <= REFILL_GAP;
          end
        end
        REFILL_GAP: begin
          state_q <= REFILL_ODD;
        end
        REFILL_ODD: begin
          if (bus_rsp_i.rvalid) begin
            state_q <= REFILL_IDLE;
            valid_q[refill_idx] <= 1'b1;
          end
        end
        default: begin
          state_q <= REFILL_IDLE;
        end
      endcase
      // a flush only comes with an accepted hit, so no refill is running.
      if (flush_i) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == REFILL_IDLE && !hit_o) begin
      refill_line_q <= pc_i[31:3];
    end
    if (state_q == REFILL_EVEN && bus_rsp_i.rvalid) begin
      data_q[refill_idx][0] <= bus_rsp_i.rdata;
      tag_q[refill_idx]     <= refill_tag;
    end
    if (state_q == REFILL_ODD && bus_rsp_i.rvalid) begin
      data_q[refill_idx][1] <= bus_rsp_i.rdata;
    end
  end

endmodule

// ==== verilog/inst_predecode.sv ====
`include "ifu_consts.svh"

module inst_predecode (
  input  logic [31:0]          inst_i,
  output ifu_pkg::inst_class_t class_o
);

  logic [6:0] opcode;

  assign opcode = inst_i[6:0];

  always_comb begin
    if (inst_i == `IFU_INST_FENCE_I) begin
      class_o = ifu_pkg::CLASS_FENCE_I;
    end else begin
      case (opcode)
        `IFU_OP_JAL,
        `IFU_OP_JALR,
        `IFU_OP_BRANCH,
        `IFU_OP_SYSTEM: begin
          // system ops are treated like jumps since the backend may trap.
          class_o = ifu_pkg::CLASS_XFER;
        end
        `IFU_OP_LOAD: begin
          class_o = ifu_pkg::CLASS_LOAD;
        end
        default: begin
          class_o = ifu_pkg::CLASS_PLAIN;
        end
      endcase
    end
  end

endmodule

// ==== verilog/fetch_sequencer.sv ====
`include "ifu_consts.svh"

module fetch_sequencer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 hit_i,
  input  ifu_pkg::inst_class_t class_i,
  input  logic                 prev_valid_i,
  input  ifu_pkg::redirect_t   redirect_i,
  input  logic                 next_ready_i,
  output logic [31:0]          pc_o,
  output logic                 flush_o,
  output logic                 valid_o,
  output logic                 ready_o
);

  logic [31:0] pc_q;
  logic        stall_q;
  logic        accept;
  logic        take_redirect;
  logic        is_xfer;
  logic        stalls_fetch;

  assign is_xfer      = (class_i == ifu_pkg::CLASS_XFER);
  assign stalls_fetch = is_xfer || (class_i == ifu_pkg::CLASS_LOAD);

  assign valid_o = hit_i && !stall_q;
  assign ready_o = !valid_o;
  assign accept  = valid_o && next_ready_i;

  // while stalled the pc still points at the jump or load, so class_i
  // describes the instruction the redirect belongs to.
  assign take_redirect = prev_valid_i && stall_q &&
                         ((redirect_i.pc_valid && is_xfer) || redirect_i.pc_skip);

  assign flush_o = accept && (class_i == ifu_pkg::CLASS_FENCE_I);
  assign pc_o    = pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= `IFU_PC_INIT;
      stall_q <= 1'b0;
    end else if (take_redirect) begin
      pc_q    <= redirect_i.npc;
      stall_q <= 1'b0;
    end else if (accept) begin
      if (stalls_fetch) begin
        stall_q <= 1'b1;
      end else begin
        // plain and fence.i both fall through to the next word.
        pc_q <= pc_q + 32'd4;
      end
    end
  end

endmodule

// ==== verilog/ifu_top.sv ====
module ifu_top (
  input  logic                 clk,
  input  logic                 rst,
  input  ifu_pkg::bus_rsp_t    bus_rsp_i,
  output ifu_pkg::bus_req_t    bus_req_o,
  input  logic                 prev_valid_i,
  input  ifu_pkg::redirect_t   redirect_i,
  input  logic                 next_ready_i,
  output ifu_pkg::fetch_out_t  fetch_o,
  output logic                 valid_o,
  output logic                 ready_o
);

  logic [31:0]          pc;
  logic [31:0]          inst;
  logic                 hit;
  logic                 flush;
  ifu_pkg::inst_class_t inst_class;

  l1i_cache l1i_cache_i (
    .clk       (clk),
    .rst       (rst),
    .pc_i      (pc),
    .flush_i   (flush),
    .bus_rsp_i (bus_rsp_i),
    .bus_req_o (bus_req_o),
    .hit_o     (hit),
    .inst_o    (inst)
  );

  inst_predecode inst_predecode_i (
    .inst_i  (inst),
    .class_o (inst_class)
  );

  fetch_sequencer fetch_sequencer_i (
    .clk          (clk),
    .rst          (rst),
    .hit_i        (hit),
    .class_i      (inst_class),
    .prev_valid_i (prev_valid_i),
    .redirect_i   (redirect_i),
    .next_ready_i (next_ready_i),
    .pc_o         (pc),
    .flush_o      (flush),
    .valid_o      (valid_o),
    .ready_o      (ready_o)
  );

  assign fetch_o.pc   = pc;
  assign fetch_o.inst = inst;

endmodule

// ==== testbench/ifu_tb.sv ====
`include "ifu_consts.svh"

module ifu_tb;

  localparam int CLK_PERIOD  = 8;
  localparam int MAX_RECORDS = 32;
  localparam int N_TESTS     = 6;

  logic                clk;
  logic                rst;
  ifu_pkg::bus_rsp_t   bus_rsp;
  ifu_pkg::bus_req_t   bus_req;
  logic                prev_valid;
  ifu_pkg::redirect_t  redirect;
  logic                next_ready;
  ifu_pkg::fetch_out_t fetch;
  logic                valid;
  logic                ready;

  ifu_top ifu_top_i (
    .clk          (clk),
    .rst          (rst),
    .bus_rsp_i    (bus_rsp),
    .bus_req_o    (bus_req),
    .prev_valid_i (prev_valid),
    .redirect_i   (redirect),
    .next_ready_i (next_ready),
    .fetch_o      (fetch),
    .valid_o      (valid),
    .ready_o      (ready)
  );

  logic [31:0] vec [0:3*MAX_RECORDS-1];
  logic [31:0] mem_addr [$];
  logic [31:0] mem_data [$];
  logic [31:0] script_npc [$];
  logic [31:0] script_pc [$];
  logic [31:0] bus_log [$];
  logic        vectors_loaded;
  logic [31:0] lfsr_q;
  logic        bus_busy;
  int          bus_wait;
  logic [31:0] bus_addr;
  int          log_seen;

  // which line the testbench expects in each set, and the copy taken at fence.i.
  logic [`IFU_L1I_TAG_W-1:0] shadow_tag [`IFU_L1I_SETS];
  logic [`IFU_L1I_SETS-1:0]  shadow_valid;
  logic [`IFU_L1I_TAG_W-1:0] flushed_tag [`IFU_L1I_SETS];
  logic [`IFU_L1I_SETS-1:0]  flushed_valid;

  logic                 waiting;
  int                   redirect_wait;
  ifu_pkg::inst_class_t stall_class;
  logic [31:0]          expect_pc;
  int                   expect_test;
  int                   si;
  logic                 hold_valid;
  ifu_pkg::fetch_out_t  held;
  logic                 done;

  int    checks [N_TESTS];
  int    errors [N_TESTS];
  string test_name [N_TESTS] = '{"reset state", "fetch correctness", "refill pattern",
                                 "stall and redirect", "fence.i", "back-pressure"};

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    // taps 32, 22, 2 and 1.
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [3:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[2:0], lfsr_q[0]};
    end
  endtask

  task automatic check(input int t, input logic ok, input string msg);
    checks[t]++;
    assert (ok) else begin
      $display("MISMATCH at %0t: %s", $time, msg);
      errors[t]++;
    end
  endtask

  task automatic load_vectors;
    logic [31:0] kind;
    $readmemh("testbench/ifu_vectors.txt", vec);
    for (int r = 0; r < MAX_RECORDS; r++) begin
      kind = vec[3*r];
      if (kind === 32'h1) begin
        mem_addr.push_back(vec[3*r+1]);
        mem_data.push_back(vec[3*r+2]);
      end else if (kind === 32'h2) begin
        script_npc.push_back(vec[3*r+1]);
        script_pc.push_back(vec[3*r+2]);
      end else begin
        break;
      end
    end
  endtask

  // words outside the image read as plain instructions that encode their address.
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] word;
    word = {addr[31:7] ^ {18'b0, addr[6:0]}, 7'b0010011};
    for (int i = 0; i < mem_addr.size(); i++) begin
      if (mem_addr[i] == addr) word = mem_data[i];
    end
    return word;
  endfunction

  function automatic ifu_pkg::inst_class_t classify(input logic [31:0] inst);
    if (inst == `IFU_INST_FENCE_I) return ifu_pkg::CLASS_FENCE_I;
    case (inst[6:0])
      `IFU_OP_JAL, `IFU_OP_JALR, `IFU_OP_BRANCH, `IFU_OP_SYSTEM: return ifu_pkg::CLASS_XFER;
      `IFU_OP_LOAD: return ifu_pkg::CLASS_LOAD;
      default: return ifu_pkg::CLASS_PLAIN;
    endcase
  endfunction

  // the memory answers a held request after 1 to 3 cycles.
  task automatic serve_bus;
    logic [3:0] r;
    bus_rsp.rvalid = 1'b0;
    if (bus_busy) begin
      check(2, bus_req.arvalid && bus_req.araddr == bus_addr,
            $sformatf("request to %h dropped or changed before its response", bus_addr));
      bus_wait--;
      if (bus_wait == 0) begin
        bus_rsp.rvalid = 1'b1;
        bus_rsp.rdata  = mem_word(bus_addr);
        bus_busy       = 1'b0;
      end
    end else if (bus_req.arvalid) begin
      rand_bits(2, r);
      bus_wait = 1 + r[1:0] % 3;
      bus_addr = bus_req.araddr;
      bus_log.push_back(bus_addr);
      bus_busy = 1'b1;
    end
  endtask

  task automatic check_refill(input logic [31:0] pc);
    logic [`IFU_L1I_IDX_W-1:0] idx;
    logic [`IFU_L1I_TAG_W-1:0] tag;
    int                        fresh;
    int                        t;
    idx   = pc[4:3];
    tag   = pc[31:5];
    fresh = bus_log.size() - log_seen;
    if (shadow_valid[idx] && shadow_tag[idx] == tag) begin
      check(2, fresh == 0, $sformatf("%0d bus reads for cached pc %h", fresh, pc));
    end else begin
      t = (flushed_valid[idx] && flushed_tag[idx] == tag) ? 4 : 2;
      check(t, fresh == 2 && bus_log[log_seen] == {pc[31:3], 3'b000} &&
            bus_log[log_seen+1] == {pc[31:3], 3'b100},
            $sformatf("refill for pc %h did not read even then odd word", pc));
      shadow_valid[idx] = 1'b1;
      shadow_tag[idx]   = tag;
    end
    log_seen = bus_log.size();
  endtask

  task automatic accept_transfer;
    logic [3:0]           r;
    ifu_pkg::inst_class_t cls;
    check(1, fetch.inst == mem_word(fetch.pc),
          $sformatf("pc %h gave %h, memory holds %h", fetch.pc, fetch.inst, mem_word(fetch.pc)));
    check(expect_test, fetch.pc == expect_pc,
          $sformatf("accepted pc %h, expected %h", fetch.pc, expect_pc));
    check_refill(fetch.pc);
    cls = classify(mem_word(expect_pc));
    if (expect_test == 3 && si == script_npc.size()) begin
      done = 1'b1;
    end else if (cls == ifu_pkg::CLASS_XFER || cls == ifu_pkg::CLASS_LOAD) begin
      if (si < script_npc.size()) begin
        waiting     = 1'b1;
        stall_class = cls;
        rand_bits(2, r);
        redirect_wait = 1 + r[1:0];
      end else begin
        $display("program reached pc %h with no redirect left in the script", fetch.pc);
        errors[3]++;
        done = 1'b1;
      end
    end else begin
      if (cls == ifu_pkg::CLASS_FENCE_I) begin
        flushed_tag   = shadow_tag;
        flushed_valid = shadow_valid;
        shadow_valid  = '0;
      end
      expect_pc   = expect_pc + 32'd4;
      expect_test = 1;
    end
  endtask

  // runs once per falling edge, where the DUT outputs are settled.
  task automatic fetch_step;
    logic [3:0] r;
    prev_valid = 1'b0;
    redirect   = '0;
    serve_bus();
    if (hold_valid) begin
      check(5, valid === 1'b1 && fetch === held,
            $sformatf("fetch output left %h/%h under back-pressure", held.pc, held.inst));
    end
    if (waiting) begin
      check(3, !valid, $sformatf("transfer offered at pc %h before the redirect", fetch.pc));
      if (redirect_wait == 0) begin
        prev_valid        = 1'b1;
        redirect.npc      = script_npc[si];
        redirect.pc_valid = (stall_class == ifu_pkg::CLASS_XFER);
        redirect.pc_skip  = (stall_class == ifu_pkg::CLASS_LOAD);
        expect_pc         = script_pc[si];
        expect_test       = 3;
        si++;
        waiting = 1'b0;
      end else begin
        redirect_wait--;
      end
    end
    rand_bits(2, r);
    next_ready = (r[1:0] != 2'b00);
    hold_valid = valid && !next_ready;
    held       = fetch;
    if (valid && next_ready) accept_transfer();
  endtask

  task automatic report_test(input int t);
    if (checks[t] == 0) begin
      $display("test %0d (%s) ran no checks", t + 1, test_name[t]);
      errors[t]++;
    end
    $display("test %0d %s: %0d checks, %0d errors", t + 1, test_name[t], checks[t], errors[t]);
  endtask

  initial begin
    int total_checks;
    int total_errors;
    rst            = 1'b1;
    bus_rsp        = '0;
    prev_valid     = 1'b0;
    redirect       = '0;
    next_ready     = 1'b0;
    vectors_loaded = 1'b0;
    lfsr_q         = 32'hc710;
    bus_busy       = 1'b0;
    log_seen       = 0;
    shadow_valid   = '0;
    flushed_valid  = '0;
    waiting        = 1'b0;
    hold_valid     = 1'b0;
    done           = 1'b0;
    si             = 0;
    expect_pc      = `IFU_PC_INIT;
    expect_test    = 1;
    load_vectors();
    vectors_loaded = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check(0, fetch.pc == `IFU_PC_INIT && valid === 1'b0 && ready === 1'b1,
          $sformatf("after reset pc %h valid %b ready %b", fetch.pc, valid, ready));
    report_test(0);
    while (!done) begin
      fetch_step();
      @(negedge clk);
    end
    total_checks = 0;
    total_errors = 0;
    for (int t = 0; t < N_TESTS; t++) begin
      if (t > 0) report_test(t);
      total_checks += checks[t];
      total_errors += errors[t];
    end
    $display("total: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    wait (vectors_loaded === 1'b1);
    repeat (200 * script_npc.size()) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", 200 * script_npc.size());
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== ifu_top.f ====
+incdir+include
verilog/ifu_pkg.sv
verilog/l1i_cache.sv
verilog/inst_predecode.sv
verilog/fetch_sequencer.sv
verilog/ifu_top.sv
testbench/ifu_tb.sv

// ==== testbench/ifu_vectors.txt ====
// columns: kind, address or npc, word or expected pc.
// kind 1 is a memory word, kind 2 a redirect with the pc expected after it, kind f ends.
1 80000000 00100093
1 80000004 00108093
1 80000008 00002103 // lw
1 8000000c 00110113
1 80000010 00000863 // beq
1 80000014 00100193
1 80000018 00200213
1 8000001c 00000073 // ecall
1 80000020 0000100f // fence.i
1 80000024 00118193
1 80000028 0000006f // jal
1 8000002c 00100293
1 80000030 00100313
1 80000034 00130313
// redirect script in fetch order.
2 8000000c 8000000c
2 80000020 80000020
2 80000008 80000008
2 8000000c 8000000c
2 80000014 80000014
2 80000030 80000030
f 00000000 00000000
